//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module tb_radio_io_core -o Vtb

run: compile
	@out=$$(./obj_dir/Vtb); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- logic/atr_gpio_ctrl.sv
// ATR daughterboard GPIO control
`timescale 1ns/1ps

module atr_gpio_ctrl #(
   parameter int RX2_PORT = 0   // odd channel, receives on the rx2 port
) (
   input  logic                        radio_clk,
   input  logic                        i_arst_n,
   input  logic                        i_rx_running,
   input  logic                        i_tx_running,
   input  radio_types_pkg::gpio_word_t i_atr_idle,
   input  radio_types_pkg::gpio_word_t i_atr_rx,
   input  radio_types_pkg::gpio_word_t i_atr_tx,
   input  radio_types_pkg::gpio_word_t i_atr_fdx,
   input  radio_types_pkg::gpio_word_t i_db_ddr,
   output radio_types_pkg::gpio_word_t o_db_gpio_out,
   output radio_types_pkg::gpio_word_t o_db_gpio_ddr,
   output radio_types_pkg::led_t       o_led
);

   radio_types_pkg::atr_mode_e  atr_mode;
   radio_types_pkg::gpio_word_t atr_word;
   radio_types_pkg::led_t       led_next;

   assign atr_mode = radio_types_pkg::atr_mode_e'({i_tx_running, i_rx_running});

   always_comb begin
      case (atr_mode)
         radio_types_pkg::RX_ONLY:     atr_word = i_atr_rx;
         radio_types_pkg::TX_ONLY:     atr_word = i_atr_tx;
         radio_types_pkg::FULL_DUPLEX: atr_word = i_atr_fdx;
         default:                      atr_word = i_atr_idle;
      endcase
   end

   // led rules, even channels receive on tx/rx unless transmitting
   always_comb begin
      led_next = '0;
      led_next[radio_types_pkg::LED_TXRX_TX] = i_tx_running;
      if (RX2_PORT != 0) begin
         led_next[radio_types_pkg::LED_RX2] = i_rx_running;
      end else begin
         led_next[radio_types_pkg::LED_TXRX_RX] = i_rx_running & ~i_tx_running;
      end
   end

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_led         <= '0;
      end else begin
         o_db_gpio_out <= atr_word;
         o_db_gpio_ddr <= i_db_ddr;
         o_led         <= led_next;
      end
   end

endmodule

//--- logic/chan_settings_regs.sv
// Channel settings registers
`timescale 1ns/1ps

module chan_settings_regs #(
   parameter int FP_SRC_CTRL = 0   // channel owns the fp source select
) (
   input  logic                        radio_clk,
   input  logic                        i_arst_n,
   input  radio_types_pkg::set_bus_t   i_set,
   input  radio_types_pkg::rb_req_t    i_rb,
   input  radio_types_pkg::gpio_word_t i_misc_in,
   input  radio_types_pkg::gpio_word_t i_db_gpio_in,
   input  radio_types_pkg::gpio_word_t i_fp_gpio_in,
   output radio_types_pkg::rb_resp_t   o_rb,
   output radio_types_pkg::gpio_word_t o_atr_idle,
   output radio_types_pkg::gpio_word_t o_atr_rx,
   output radio_types_pkg::gpio_word_t o_atr_tx,
   output radio_types_pkg::gpio_word_t o_atr_fdx,
   output radio_types_pkg::gpio_word_t o_db_ddr,
   output radio_types_pkg::gpio_word_t o_fp_out,
   output radio_types_pkg::gpio_word_t o_fp_ddr,
   output radio_types_pkg::gpio_word_t o_fp_src,
   output radio_types_pkg::gpio_word_t o_misc_out
);

   radio_types_pkg::gpio_word_t rb_word;

   ////////////////////////////////////////////////////////////////////////////
   // settings write decode
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_atr_idle <= '0;
         o_atr_rx   <= '0;
         o_atr_tx   <= '0;
         o_atr_fdx  <= '0;
         o_db_ddr   <= '0;   // all dboard pins start as inputs
         o_fp_out   <= '0;
         o_fp_ddr   <= '0;
         o_misc_out <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            radio_regmap_pkg::SR_ATR_IDLE: o_atr_idle <= i_set.data;
            radio_regmap_pkg::SR_ATR_RX:   o_atr_rx   <= i_set.data;
            radio_regmap_pkg::SR_ATR_TX:   o_atr_tx   <= i_set.data;
            radio_regmap_pkg::SR_ATR_FDX:  o_atr_fdx  <= i_set.data;
            radio_regmap_pkg::SR_DB_DDR:   o_db_ddr   <= i_set.data;
            radio_regmap_pkg::SR_FP_OUT:   o_fp_out   <= i_set.data;
            radio_regmap_pkg::SR_FP_DDR:   o_fp_ddr   <= i_set.data;
            radio_regmap_pkg::SR_MISC_OUT: o_misc_out <= i_set.data;
            default: ;   // unknown address, write dropped
         endcase
      end
   end

   // only the source-select owner keeps this word
   if (FP_SRC_CTRL != 0) begin : g_fp_src
      always_ff @(posedge radio_clk or negedge i_arst_n) begin
         if (!i_arst_n) begin
            o_fp_src <= '0;
         end else if (i_set.stb && (i_set.addr == radio_regmap_pkg::SR_FP_SRC)) begin
            o_fp_src <= i_set.data;
         end
      end
   end else begin : g_no_fp_src
      assign o_fp_src = '0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // readback
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (i_rb.addr)
         radio_regmap_pkg::RB_MISC_IN:    rb_word = i_misc_in;
         radio_regmap_pkg::RB_DB_GPIO_IN: rb_word = i_db_gpio_in;
         radio_regmap_pkg::RB_FP_GPIO_IN: rb_word = i_fp_gpio_in;
         radio_regmap_pkg::RB_MISC_OUT:   rb_word = o_misc_out;
         default:                         rb_word = '0;
      endcase
   end

   // one response per request, valid for a single cycle
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rb.valid <= 1'b0;
         o_rb.data  <= '0;
      end else begin
         o_rb.valid <= i_rb.stb;
         if (i_rb.stb) begin
            o_rb.data <= rb_word;
         end
      end
   end

endmodule

//--- logic/db_io_map.sv
// Board pin mapping
`timescale 1ns/1ps

module db_io_map #(
   parameter int FP_GPIO_WIDTH = 12
) (
   input  logic                        radio_clk,
   input  logic                        i_arst_n,
   // per channel
   input  radio_types_pkg::gpio_word_t i_fp_out      [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::gpio_word_t i_fp_ddr      [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::gpio_word_t i_db_gpio_out [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::gpio_word_t i_db_gpio_ddr [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::gpio_word_t i_misc_out    [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::led_t       i_led         [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::gpio_word_t i_fp_src,   // channel 0 source select
   // board inputs
   input  radio_types_pkg::gpio_word_t i_fp_gpio_in,
   input  radio_types_pkg::gpio_word_t i_db_gpio_in  [radio_types_pkg::NUM_DBOARDS],
   input  radio_types_pkg::gpio_word_t i_misc_in     [radio_types_pkg::NUM_DBOARDS],
   // board outputs
   output radio_types_pkg::gpio_word_t o_fp_gpio_out,
   output radio_types_pkg::gpio_word_t o_fp_gpio_ddr,
   output radio_types_pkg::gpio_word_t o_db_gpio_out [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::gpio_word_t o_db_gpio_ddr [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::gpio_word_t o_misc_out    [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::led_t       o_radio_led   [radio_types_pkg::NUM_DBOARDS],
   // back to the channels
   output radio_types_pkg::gpio_word_t o_chan_misc_in    [radio_types_pkg::NUM_CHANNELS],
   output radio_types_pkg::gpio_word_t o_chan_db_gpio_in [radio_types_pkg::NUM_CHANNELS],
   output radio_types_pkg::gpio_word_t o_chan_fp_gpio_in [radio_types_pkg::NUM_CHANNELS]
);

   localparam int W = $bits(radio_types_pkg::gpio_word_t);
   localparam radio_types_pkg::gpio_word_t FP_MASK =
      (FP_GPIO_WIDTH >= W) ? {W{1'b1}} : ((W'(1) << FP_GPIO_WIDTH) - W'(1));
   localparam int DB_CH = radio_types_pkg::CHANS_PER_DB;

   radio_types_pkg::gpio_word_t misc_in_q [radio_types_pkg::NUM_DBOARDS];

   ////////////////////////////////////////////////////////////////////////////
   // front-panel gpio, bitwise pick of channel 0 or channel 2
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_out <= ((i_fp_out[0] & ~i_fp_src) | (i_fp_out[DB_CH] & i_fp_src)) & FP_MASK;
         o_fp_gpio_ddr <= ((i_fp_ddr[0] & ~i_fp_src) | (i_fp_ddr[DB_CH] & i_fp_src)) & FP_MASK;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // daughterboard pins, first channel of each board drives them
   ////////////////////////////////////////////////////////////////////////////
   for (genvar d = 0; d < radio_types_pkg::NUM_DBOARDS; d++) begin : g_db
      assign o_db_gpio_out[d] = i_db_gpio_out[d*DB_CH];
      assign o_db_gpio_ddr[d] = i_db_gpio_ddr[d*DB_CH];
      assign o_radio_led[d]   = i_led[d*DB_CH] | i_led[d*DB_CH+1];   // overlay of both chans

      always_ff @(posedge radio_clk or negedge i_arst_n) begin
         if (!i_arst_n) begin
            o_misc_out[d] <= '0;
            misc_in_q[d]  <= '0;
         end else begin
            o_misc_out[d] <= i_misc_out[d*DB_CH];
            misc_in_q[d]  <= i_misc_in[d];
         end
      end
   end

   // second channel of a board sees no inputs
   for (genvar c = 0; c < radio_types_pkg::NUM_CHANNELS; c++) begin : g_chan_in
      if ((c % DB_CH) == 0) begin : g_primary
         assign o_chan_misc_in[c]    = misc_in_q[c/DB_CH];
         assign o_chan_db_gpio_in[c] = i_db_gpio_in[c/DB_CH];
         assign o_chan_fp_gpio_in[c] = i_fp_gpio_in;
      end else begin : g_secondary
         assign o_chan_misc_in[c]    = '0;
         assign o_chan_db_gpio_in[c] = '0;
         assign o_chan_fp_gpio_in[c] = '0;
      end
   end

endmodule

//--- logic/radio_io_core.sv
// Radio front-end IO core
`timescale 1ns/1ps

module radio_io_core #(
   parameter int FP_GPIO_WIDTH = 12
) (
   input  logic                        radio_clk,
   input  logic                        i_arst_n,
   // radio core side
   input  radio_types_pkg::set_bus_t   i_set [radio_types_pkg::NUM_CHANNELS],
   input  radio_types_pkg::rb_req_t    i_rb  [radio_types_pkg::NUM_CHANNELS],
   input  logic [radio_types_pkg::NUM_CHANNELS-1:0] i_rx_running,
   input  logic [radio_types_pkg::NUM_CHANNELS-1:0] i_tx_running,
   output radio_types_pkg::rb_resp_t   o_rb  [radio_types_pkg::NUM_CHANNELS],
   // board pins
   input  radio_types_pkg::gpio_word_t i_fp_gpio_in,
   input  radio_types_pkg::gpio_word_t i_db_gpio_in [radio_types_pkg::NUM_DBOARDS],
   input  radio_types_pkg::gpio_word_t i_misc_in    [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::gpio_word_t o_fp_gpio_out,
   output radio_types_pkg::gpio_word_t o_fp_gpio_ddr,
   output radio_types_pkg::gpio_word_t o_db_gpio_out [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::gpio_word_t o_db_gpio_ddr [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::gpio_word_t o_misc_out    [radio_types_pkg::NUM_DBOARDS],
   output radio_types_pkg::led_t       o_radio_led   [radio_types_pkg::NUM_DBOARDS]
);

   localparam int NCH = radio_types_pkg::NUM_CHANNELS;

   // settings to atr
   radio_types_pkg::gpio_word_t atr_idle [NCH];
   radio_types_pkg::gpio_word_t atr_rx   [NCH];
   radio_types_pkg::gpio_word_t atr_tx   [NCH];
   radio_types_pkg::gpio_word_t atr_fdx  [NCH];
   radio_types_pkg::gpio_word_t db_ddr   [NCH];

   // channel to pin map
   radio_types_pkg::gpio_word_t fp_out      [NCH];
   radio_types_pkg::gpio_word_t fp_ddr      [NCH];
   radio_types_pkg::gpio_word_t fp_src      [NCH];   // only chan 0 is nonzero
   radio_types_pkg::gpio_word_t misc_out    [NCH];
   radio_types_pkg::gpio_word_t db_gpio_out [NCH];
   radio_types_pkg::gpio_word_t db_gpio_ddr [NCH];
   radio_types_pkg::led_t       led         [NCH];

   // pin map back to readback
   radio_types_pkg::gpio_word_t chan_misc_in    [NCH];
   radio_types_pkg::gpio_word_t chan_db_gpio_in [NCH];
   radio_types_pkg::gpio_word_t chan_fp_gpio_in [NCH];

   ////////////////////////////////////////////////////////////////////////////
   // per channel front-end control
   ////////////////////////////////////////////////////////////////////////////
   for (genvar c = 0; c < NCH; c++) begin : g_chan
      chan_settings_regs #(
         .FP_SRC_CTRL (c == 0)
      ) u_regs (
         .radio_clk    (radio_clk),
         .i_arst_n     (i_arst_n),
         .i_set        (i_set[c]),
         .i_rb         (i_rb[c]),
         .i_misc_in    (chan_misc_in[c]),
         .i_db_gpio_in (chan_db_gpio_in[c]),
         .i_fp_gpio_in (chan_fp_gpio_in[c]),
         .o_rb         (o_rb[c]),
         .o_atr_idle   (atr_idle[c]),
         .o_atr_rx     (atr_rx[c]),
         .o_atr_tx     (atr_tx[c]),
         .o_atr_fdx    (atr_fdx[c]),
         .o_db_ddr     (db_ddr[c]),
         .o_fp_out     (fp_out[c]),
         .o_fp_ddr     (fp_ddr[c]),
         .o_fp_src     (fp_src[c]),
         .o_misc_out   (misc_out[c])
      );

      atr_gpio_ctrl #(
         .RX2_PORT (c % 2)
      ) u_atr (
         .radio_clk     (radio_clk),
         .i_arst_n      (i_arst_n),
         .i_rx_running  (i_rx_running[c]),
         .i_tx_running  (i_tx_running[c]),
         .i_atr_idle    (atr_idle[c]),
         .i_atr_rx      (atr_rx[c]),
         .i_atr_tx      (atr_tx[c]),
         .i_atr_fdx     (atr_fdx[c]),
         .i_db_ddr      (db_ddr[c]),
         .o_db_gpio_out (db_gpio_out[c]),
         .o_db_gpio_ddr (db_gpio_ddr[c]),
         .o_led         (led[c])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // board pin mapping
   ////////////////////////////////////////////////////////////////////////////
   db_io_map #(
      .FP_GPIO_WIDTH (FP_GPIO_WIDTH)
   ) u_io_map (
      .radio_clk         (radio_clk),
      .i_arst_n          (i_arst_n),
      .i_fp_out          (fp_out),
      .i_fp_ddr          (fp_ddr),
      .i_db_gpio_out     (db_gpio_out),
      .i_db_gpio_ddr     (db_gpio_ddr),
      .i_misc_out        (misc_out),
      .i_led             (led),
      .i_fp_src          (fp_src[0]),
      .i_fp_gpio_in      (i_fp_gpio_in),
      .i_db_gpio_in      (i_db_gpio_in),
      .i_misc_in         (i_misc_in),
      .o_fp_gpio_out     (o_fp_gpio_out),
      .o_fp_gpio_ddr     (o_fp_gpio_ddr),
      .o_db_gpio_out     (o_db_gpio_out),
      .o_db_gpio_ddr     (o_db_gpio_ddr),
      .o_misc_out        (o_misc_out),
      .o_radio_led       (o_radio_led),
      .o_chan_misc_in    (chan_misc_in),
      .o_chan_db_gpio_in (chan_db_gpio_in),
      .o_chan_fp_gpio_in (chan_fp_gpio_in)
   );

endmodule

//--- logic/radio_regmap_pkg.sv
// Radio channel register map
package radio_regmap_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // setting addresses
   ////////////////////////////////////////////////////////////////////////////
   localparam radio_types_pkg::set_addr_t SR_MISC_OUT = 8'h00;   // misc output word
   localparam radio_types_pkg::set_addr_t SR_FP_SRC   = 8'h01;   // fp source select, chan 0
   localparam radio_types_pkg::set_addr_t SR_FP_OUT   = 8'h02;   // front-panel gpio out
   localparam radio_types_pkg::set_addr_t SR_FP_DDR   = 8'h03;   // front-panel gpio direction
   localparam radio_types_pkg::set_addr_t SR_DB_DDR   = 8'h04;   // dboard gpio direction

   // atr values, one per running combination
   localparam radio_types_pkg::set_addr_t SR_ATR_IDLE = 8'h08;
   localparam radio_types_pkg::set_addr_t SR_ATR_RX   = 8'h09;
   localparam radio_types_pkg::set_addr_t SR_ATR_TX   = 8'h0A;
   localparam radio_types_pkg::set_addr_t SR_ATR_FDX  = 8'h0B;

   ////////////////////////////////////////////////////////////////////////////
   // readback addresses
   ////////////////////////////////////////////////////////////////////////////
   // misc in is the registered board input, zero on odd channels
   localparam radio_types_pkg::set_addr_t RB_MISC_IN    = 8'h00;
   localparam radio_types_pkg::set_addr_t RB_DB_GPIO_IN = 8'h01;
   localparam radio_types_pkg::set_addr_t RB_FP_GPIO_IN = 8'h02;
   localparam radio_types_pkg::set_addr_t RB_MISC_OUT   = 8'h03;   // echo of SR_MISC_OUT

endpackage

//--- logic/radio_types_pkg.sv
// Radio IO shared types
package radio_types_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // board shape
   ////////////////////////////////////////////////////////////////////////////
   localparam int NUM_CHANNELS = 4;
   localparam int NUM_DBOARDS  = 2;
   localparam int CHANS_PER_DB = 2;   // two radio channels share one dboard

   // word carried on gpio, misc and readback paths
   typedef logic [31:0] gpio_word_t;

   // settings and readback address
   typedef logic [7:0] set_addr_t;

   // front-end leds, {rx2, txrx_tx, txrx_rx}
   typedef logic [2:0] led_t;

   localparam int LED_TXRX_RX = 0;
   localparam int LED_TXRX_TX = 1;
   localparam int LED_RX2     = 2;

   ////////////////////////////////////////////////////////////////////////////
   // channel control buses
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic       stb;
      set_addr_t  addr;
      gpio_word_t data;
   } set_bus_t;   // 41 bits

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
   } rb_req_t;    // 9 bits

   typedef struct packed {
      logic       valid;
      gpio_word_t data;
   } rb_resp_t;   // 33 bits

   // atr mode, encoded as {tx_running, rx_running}
   typedef enum logic [1:0] {
      IDLE        = 2'b00,
      RX_ONLY     = 2'b01,
      TX_ONLY     = 2'b10,
      FULL_DUPLEX = 2'b11
   } atr_mode_e;

endpackage

//--- tb.f
logic/radio_types_pkg.sv
logic/radio_regmap_pkg.sv
logic/chan_settings_regs.sv
logic/atr_gpio_ctrl.sv
logic/db_io_map.sv
logic/radio_io_core.sv
test/tb_radio_io_core.sv

//--- test/radio_io_golden.txt
# W ch addr data | R ch addr expected | L rx_mask tx_mask
# P pin expected (0 fp out, 1 fp ddr, 2/3 db out, 4/5 db ddr, 6/7 misc, 8/9 led, a valid)
P 0 0
P 1 0
P 2 0
P 3 0
P 4 0
P 5 0
P 6 0
P 7 0
P 8 0
P 9 0
P a 0
W 1 00 11110001
R 1 03 11110001
W 0 00 a5a5000f
W 2 00 5a5a00f0
R 0 03 a5a5000f
P 6 a5a5000f
P 7 5a5a00f0
I 000000c3 0000003c 12345678 9abcdef0 00000fff
R 0 00 000000c3
R 2 00 0000003c
R 1 00 00000000
R 3 00 00000000
R 0 09 00000000
R 2 01 9abcdef0
W 0 08 00000001
W 0 09 00000002
W 0 0a 00000004
W 0 0b 00000008
W 2 08 00000100
W 2 09 00000200
W 2 0a 00000400
W 2 0b 00000800
W 0 04 0000ffff
W 2 04 ffff0000
L 0 0
P 2 00000001
P 3 00000100
P 4 0000ffff
P 5 ffff0000
L 5 0
P 2 00000002
P 3 00000200
P 8 1
P 9 1
L 0 5
P 2 00000004
P 3 00000400
P 8 2
L 5 5
P 2 00000008
P 3 00000800
P 9 2
L b 0
P 2 00000002
P 8 5
P 9 4
L 3 2
P 8 7
W 0 02 ffffffff
W 2 02 00000000
W 0 03 00000000
W 2 03 ffffffff
W 0 01 00000f0f
P 0 000000f0
P 1 00000f0f
W 2 01 ffffffff
P 0 000000f0
W 0 01 00000000
P 0 00000fff
P 1 00000000

//--- test/tb_radio_io_core.sv
// Radio IO core testbench
`timescale 1ns/1ps

module tb_radio_io_core;

   localparam int NCH = radio_types_pkg::NUM_CHANNELS;
   localparam int NDB = radio_types_pkg::NUM_DBOARDS;

   logic                        radio_clk;
   logic                        i_arst_n;
   radio_types_pkg::set_bus_t   set_bus  [NCH];
   radio_types_pkg::rb_req_t    rb_req   [NCH];
   radio_types_pkg::rb_resp_t   rb_resp  [NCH];
   logic [NCH-1:0]              rx_run;
   logic [NCH-1:0]              tx_run;
   radio_types_pkg::gpio_word_t fp_gpio_in;
   radio_types_pkg::gpio_word_t db_gpio_in  [NDB];
   radio_types_pkg::gpio_word_t misc_in     [NDB];
   radio_types_pkg::gpio_word_t fp_gpio_out;
   radio_types_pkg::gpio_word_t fp_gpio_ddr;
   radio_types_pkg::gpio_word_t db_gpio_out [NDB];
   radio_types_pkg::gpio_word_t db_gpio_ddr [NDB];
   radio_types_pkg::gpio_word_t misc_out    [NDB];
   radio_types_pkg::led_t       radio_led   [NDB];

   int unsigned cycles;
   int unsigned cycle_limit;

   radio_io_core #(
      .FP_GPIO_WIDTH (12)
   ) dut (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_set         (set_bus),
      .i_rb          (rb_req),
      .i_rx_running  (rx_run),
      .i_tx_running  (tx_run),
      .o_rb          (rb_resp),
      .i_fp_gpio_in  (fp_gpio_in),
      .i_db_gpio_in  (db_gpio_in),
      .i_misc_in     (misc_in),
      .o_fp_gpio_out (fp_gpio_out),
      .o_fp_gpio_ddr (fp_gpio_ddr),
      .o_db_gpio_out (db_gpio_out),
      .o_db_gpio_ddr (db_gpio_ddr),
      .o_misc_out    (misc_out),
      .o_radio_led   (radio_led)
   );

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;   // 40 ns period
   end

   // run limit guard
   always @(posedge radio_clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("run timed out after %0d cycles", cycles);
         $display("tests failed");
         $fatal(1, "timeout");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks and bus operations
   ////////////////////////////////////////////////////////////////////////////
   task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("tests failed");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic write_setting(input int ch, input logic [7:0] addr, input logic [31:0] data);
      @(posedge radio_clk);
      set_bus[ch] <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge radio_clk);
      set_bus[ch].stb <= 1'b0;   // write sampled on this edge
   endtask

   task automatic read_check(input int ch, input logic [7:0] addr, input logic [31:0] exp);
      @(posedge radio_clk);
      rb_req[ch] <= '{stb: 1'b1, addr: addr};
      @(posedge radio_clk);
      rb_req[ch].stb <= 1'b0;
      @(negedge radio_clk);
      while (!rb_resp[ch].valid) begin
         @(negedge radio_clk);
      end
      compare_word(rb_resp[ch].data, exp, $sformatf("readback ch %0d addr %h", ch, addr));
      @(negedge radio_clk);   // one request, one valid cycle
      compare_word(32'(rb_resp[ch].valid), 32'h0,
                   $sformatf("readback valid ch %0d held past one cycle", ch));
   endtask

   // pins settle two edges after the last sampled input
   task automatic pin_check(input logic [7:0] id, input logic [31:0] exp);
      logic [31:0] got;
      repeat (2) @(posedge radio_clk);
      @(negedge radio_clk);
      case (id)
         8'h0: got = fp_gpio_out;
         8'h1: got = fp_gpio_ddr;
         8'h2: got = db_gpio_out[0];
         8'h3: got = db_gpio_out[1];
         8'h4: got = db_gpio_ddr[0];
         8'h5: got = db_gpio_ddr[1];
         8'h6: got = misc_out[0];
         8'h7: got = misc_out[1];
         8'h8: got = 32'(radio_led[0]);
         8'h9: got = 32'(radio_led[1]);
         default: got = 32'({rb_resp[3].valid, rb_resp[2].valid,
                             rb_resp[1].valid, rb_resp[0].valid});
      endcase
      compare_word(got, exp, $sformatf("pin %h", id));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // golden file driver
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int          fd;
      int          n_lines;
      int          n_ops;
      string       line;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      logic [31:0] e;
      cycles      = 0;
      cycle_limit = 32'hffff_ffff;
      i_arst_n    = 1'b0;
      rx_run      = '0;
      tx_run      = '0;
      fp_gpio_in  = '0;
      for (int i = 0; i < NCH; i++) begin
         set_bus[i] = '0;
         rb_req[i]  = '0;
      end
      for (int i = 0; i < NDB; i++) begin
         db_gpio_in[i] = '0;
         misc_in[i]    = '0;
      end
      n_lines = 0;
      n_ops   = 0;
      fd = $fopen("test/radio_io_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open the golden file");
         $display("tests failed");
         $fatal(1, "no golden file");
      end
      while ($fgets(line, fd) > 0) begin
         n_lines++;
      end
      $fclose(fd);
      cycle_limit = 4 * n_lines + 20;
      repeat (8) @(posedge radio_clk);
      i_arst_n <= 1'b1;
      fd = $fopen("test/radio_io_golden.txt", "r");
      while ($fgets(line, fd) > 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         void'($sscanf(line, "%c %h %h %h %h %h", op, a, b, c, d, e));
         n_ops++;
         case (op)
            "W": write_setting(int'(a), b[7:0], c);
            "R": read_check(int'(a), b[7:0], c);
            "P": pin_check(a[7:0], b);
            "L": begin
               @(posedge radio_clk);
               rx_run <= a[NCH-1:0];
               tx_run <= b[NCH-1:0];
            end
            "I": begin
               @(posedge radio_clk);
               misc_in[0]    <= a;
               misc_in[1]    <= b;
               db_gpio_in[0] <= c;
               db_gpio_in[1] <= d;
               fp_gpio_in    <= e;
            end
            default: begin
               $display("unknown operation in golden line: %s", line);
               $display("tests failed");
               $fatal(1, "bad golden line");
            end
         endcase
      end
      $fclose(fd);
      if (n_ops == 0) begin
         $display("golden file held no operations");
         $display("tests failed");
         $fatal(1, "empty golden file");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule
